//--- Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= all tests passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) program.hex
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- program.hex
// one rv32i instruction word per line, line n sits at byte address 4*n
// arithmetic 0x00..0x14, loop 0x18..0x30, memory 0x34..0x3c, calls 0x40..0x5c
00700293
00300313
40628533
01154513
00151513
005323B3
00000513
00100293
00600313
00550533
00128293
FE629CE3
00534463
5A500393
00702623
00C02503
018000EF
00000597
12345537
00B50533
FBC50513
0000006F
00150513
00008067

//--- sim.f
verilog/rv_pkg.sv
verilog/fetch_unit.sv
verilog/control_unit.sv
verilog/imm_gen.sv
verilog/register_file.sv
verilog/alu.sv
verilog/data_mem.sv
verilog/rv_core.sv
testbench/rv_core_chk.sv
testbench/rv_core_tb.sv

//--- testbench/rv_core_chk.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_chk (
    input logic                    clk,
    input logic                    rst,
    input logic [rv_pkg::xlen-1:0] pc_i,
    input logic                    run_i,
    input logic [rv_pkg::xlen-1:0] rd_val_i  // stored value of the current rd
);

    // fetch only produces word addresses
    pc_aligned: assert property (@(posedge clk) disable iff (rst) pc_i[1:0] == 2'b00)
        else $error("pc 0x%08h is not word aligned", pc_i);

    // stalled core keeps pc over the next edge
    pc_held: assert property (@(posedge clk) disable iff (rst) !run_i |=> $stable(pc_i))
        else $error("pc moved while run was low");

    // held instruction must not reach its destination register
    no_early_write: assert property (@(posedge clk) disable iff (rst)
                                     !run_i |=> $stable(rd_val_i))
        else $error("register file written while run was low");

endmodule

bind rv_core rv_core_chk u_chk (
    .clk(clk), .rst(rst), .pc_i(pc), .run_i(run), .rd_val_i(u_rf.regs[instr.r.rd])
);

`default_nettype wire

//--- testbench/rv_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_tb;

    localparam int rst_cycles  = 3;
    localparam int hold_min    = 5;
    localparam int hold_max    = 20;
    localparam int prog_max    = 120;  // program retires well inside this
    localparam int halt_cycles = 5;
    localparam int need_cycles = rst_cycles + hold_max + 2 + prog_max + halt_cycles;
    localparam int max_cycles  = 2 * need_cycles + 100; // 400

    // marker addresses in program.hex
    localparam logic [31:0] arith_pc = 32'h18; // a0 clear, arithmetic result still in a0
    localparam logic [31:0] loop_pc  = 32'h34; // after the not-taken blt
    localparam logic [31:0] load_pc  = 32'h40; // jal right after lw
    localparam logic [31:0] ret_pc   = 32'h44; // jalr lands here
    localparam logic [31:0] halt_pc  = 32'h54; // jal x0, 0

    localparam logic [31:0] arith_exp = ((32'd7 - 32'd3) ^ 32'h11) << 1; // 42
    localparam logic [31:0] loop_exp  = 32'd1 + 32'd2 + 32'd3 + 32'd4 + 32'd5;
    localparam logic [31:0] mem_exp   = 32'h5a5;
    localparam logic [31:0] call_exp  = mem_exp + 32'd1;
    localparam logic [31:0] upper_exp = 32'h12345000;

    logic                    clk;
    logic                    rst;
    logic                    trigger;
    logic [rv_pkg::xlen-1:0] pc;
    logic [rv_pkg::xlen-1:0] instr;
    logic [rv_pkg::xlen-1:0] a0;

    logic [rv_pkg::xlen-1:0] prog [rv_pkg::imem_words]; // tb copy of the rom
    int cycle_count = 0;
    int check_errs = 0;
    int fetch_errs = 0;
    int fetch_checked = 0;
    int tests_run = 0;
    int tests_failed = 0;

    rv_core i_dut (
        .clk(clk), .rst(rst), .trigger_i(trigger),
        .pc_o(pc), .instr_o(instr), .a0_o(a0)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period
    end

    // watchdog
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("tests failed");
            $finish;
        end
    end

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        check_errs++;
        $display("** Error at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        tests_run++;
        if (check_errs != errs_at_start) begin
            tests_failed++;
            $display("%s: FAIL", name);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    // one retiring edge, then the fetch rule at the falling edge
    task automatic step_cycle();
        logic [31:0] old_pc;
        logic [6:0]  op;
        logic        redirect;
        old_pc   = pc;
        op       = instr[6:0];
        redirect = (op == rv_pkg::op_jal) || (op == rv_pkg::op_jalr) ||
                   (op == rv_pkg::op_branch);
        @(posedge clk);
        @(negedge clk);
        if (!redirect && pc != old_pc + 32'd4) begin
            fetch_errs++;
            $display("** Error at %0t: pc is 0x%08h, expected 0x%08h", $time, pc, old_pc + 32'd4);
        end
        if (instr != prog[pc[rv_pkg::imem_aw+1:2]]) begin
            fetch_errs++;
            $display("** Error at %0t: instr is 0x%08h at pc 0x%08h, expected 0x%08h",
                     $time, instr, pc, prog[pc[rv_pkg::imem_aw+1:2]]);
        end
        fetch_checked++;
    endtask

    task automatic run_until(input logic [31:0] target);
        int n;
        n = 0;
        while (pc != target && n < prog_max) begin
            step_cycle();
            n++;
        end
        if (pc != target) begin
            check_errs++;
            $display("pc did not reach 0x%08h within %0d cycles", target, prog_max);
        end
    endtask

    task automatic hold_before_trigger();
        int hold_len;
        int errs;
        errs     = check_errs;
        hold_len = hold_min + int'($urandom % (hold_max - hold_min + 1));
        for (int k = 0; k < hold_len; k++) begin
            @(posedge clk);
            @(negedge clk);
            if (pc != rv_pkg::reset_pc) report_mismatch("pc while held", pc, rv_pkg::reset_pc);
            if (instr != prog[0]) report_mismatch("instr while held", instr, prog[0]);
            if (a0 != '0) report_mismatch("a0 while held", a0, '0);
        end
        trigger = 1'b1;   // sampled on the next rising edge
        @(posedge clk);
        @(negedge clk);
        trigger = 1'b0;
        if (pc != rv_pkg::reset_pc) report_mismatch("pc on latch edge", pc, rv_pkg::reset_pc);
        step_cycle();     // first retire
        if (pc != rv_pkg::reset_pc + 32'd4) begin
            report_mismatch("pc after trigger", pc, rv_pkg::reset_pc + 32'd4);
        end
        finish_test("hold before trigger", errs);
    endtask

    task automatic arith_and_loop();
        int errs;
        errs = check_errs;
        run_until(arith_pc);
        if (a0 != arith_exp) report_mismatch("a0 after arithmetic", a0, arith_exp);
        run_until(loop_pc);
        if (a0 != loop_exp) report_mismatch("a0 after loop", a0, loop_exp);
        finish_test("arithmetic and loop", errs);
    endtask

    task automatic memory_round_trip();
        int errs;
        errs = check_errs;
        run_until(load_pc);
        if (a0 != mem_exp) report_mismatch("a0 after lw", a0, mem_exp);
        finish_test("memory round trip", errs);
    endtask

    task automatic calls_and_halt();
        int errs;
        errs = check_errs;
        run_until(ret_pc);
        if (a0 != call_exp) report_mismatch("a0 after jalr return", a0, call_exp);
        run_until(halt_pc);
        if (a0 != upper_exp) report_mismatch("a0 at halt", a0, upper_exp);
        for (int k = 0; k < halt_cycles; k++) begin
            step_cycle();
            if (pc != halt_pc) report_mismatch("pc at halt", pc, halt_pc);
        end
        finish_test("jump, link and upper immediates", errs);
    endtask

    // fetch rule ran on every retired cycle above
    task automatic fetch_rule_result();
        tests_run++;
        if (fetch_errs != 0 || fetch_checked == 0) begin
            tests_failed++;
            $display("fetch rule: FAIL (%0d cycles seen)", fetch_checked);
        end else begin
            $display("fetch rule: ok (%0d cycles seen)", fetch_checked);
        end
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(30152));
        rst     = 1'b1;
        trigger = 1'b0;
        $readmemh("program.hex", prog);
        repeat (rst_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        hold_before_trigger();
        arith_and_loop();
        memory_round_trip();
        calls_and_halt();
        fetch_rule_result();

        $display("summary: %0d tests run, %0d failed, %0d value errors, %0d fetch errors",
                 tests_run, tests_failed, check_errs, fetch_errs);
        if (tests_failed == 0 && check_errs == 0 && fetch_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  logic [rv_pkg::xlen-1:0] a_i,
    input  logic [rv_pkg::xlen-1:0] b_i,
    input  rv_pkg::alu_op_e         op_i,
    output logic [rv_pkg::xlen-1:0] result_o,
    output logic                    eq_o,
    output logic                    lt_o,  // signed a < b
    output logic                    ltu_o  // unsigned a < b
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0]; // only low 5 bits shift

    // flags ignore op_i, branches read them directly
    assign eq_o  = (a_i == b_i);
    assign lt_o  = ($signed(a_i) < $signed(b_i));
    assign ltu_o = (a_i < b_i);

    always_comb begin
        case (op_i)
            rv_pkg::alu_add:  result_o = a_i + b_i;
            rv_pkg::alu_sub:  result_o = a_i - b_i;
            rv_pkg::alu_and:  result_o = a_i & b_i;
            rv_pkg::alu_or:   result_o = a_i | b_i;
            rv_pkg::alu_xor:  result_o = a_i ^ b_i;
            rv_pkg::alu_slt:  result_o = {31'b0, lt_o};
            rv_pkg::alu_sltu: result_o = {31'b0, ltu_o};
            rv_pkg::alu_sll:  result_o = a_i << shamt;
            rv_pkg::alu_srl:  result_o = a_i >> shamt;
            rv_pkg::alu_sra:  result_o = $unsigned($signed(a_i) >>> shamt); // keeps sign
            default:          result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/control_unit.sv
`timescale 1ns/10ps
`default_nettype none

module control_unit (
    input  rv_pkg::instr_u   instr_i,
    input  logic             eq_i,
    input  logic             lt_i,
    input  logic             ltu_i,
    output logic             reg_wr_en_o,
    output logic             mem_wr_en_o,
    output rv_pkg::imm_sel_e imm_sel_o,
    output rv_pkg::alu_op_e  alu_op_o,
    output logic [1:0]       src_a_sel_o,
    output logic             src_b_sel_o,  // 1 = immediate
    output logic [1:0]       result_sel_o,
    output logic             pc_src_o,
    output logic             jalr_sel_o    // target base from rs1
);

    rv_pkg::alu_op_e funct_op;
    logic            taken;

    // funct3/funct7 to alu op, shared by r and i types
    always_comb begin
        case (instr_i.r.funct3)
            3'b000: funct_op = (instr_i.r.opcode == rv_pkg::op_rtype && instr_i.r.funct7[5])
                               ? rv_pkg::alu_sub : rv_pkg::alu_add; // no subi
            3'b001: funct_op = rv_pkg::alu_sll;
            3'b010: funct_op = rv_pkg::alu_slt;
            3'b011: funct_op = rv_pkg::alu_sltu;
            3'b100: funct_op = rv_pkg::alu_xor;
            3'b101: funct_op = instr_i.r.funct7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110: funct_op = rv_pkg::alu_or;
            default: funct_op = rv_pkg::alu_and;
        endcase
    end

    // branch condition from funct3 and the alu flags
    always_comb begin
        case (instr_i.r.funct3)
            3'b000: taken = eq_i;    // beq
            3'b001: taken = !eq_i;   // bne
            3'b100: taken = lt_i;    // blt
            3'b101: taken = !lt_i;   // bge
            3'b110: taken = ltu_i;   // bltu
            3'b111: taken = !ltu_i;  // bgeu
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        reg_wr_en_o  = 1'b0; // unknown opcode does nothing
        mem_wr_en_o  = 1'b0;
        imm_sel_o    = rv_pkg::imm_i;
        alu_op_o     = rv_pkg::alu_add;
        src_a_sel_o  = rv_pkg::src_a_reg;
        src_b_sel_o  = 1'b1;
        result_sel_o = rv_pkg::res_alu;
        pc_src_o     = 1'b0;
        jalr_sel_o   = 1'b0;
        case (instr_i.r.opcode)
            rv_pkg::op_rtype: begin
                reg_wr_en_o = 1'b1;
                src_b_sel_o = 1'b0;
                alu_op_o    = funct_op;
            end
            rv_pkg::op_itype: begin
                reg_wr_en_o = 1'b1;
                alu_op_o    = funct_op;
            end
            rv_pkg::op_load: begin
                reg_wr_en_o  = 1'b1;
                result_sel_o = rv_pkg::res_mem;
            end
            rv_pkg::op_store: begin
                mem_wr_en_o = 1'b1;
                imm_sel_o   = rv_pkg::imm_s;
            end
            rv_pkg::op_branch: begin
                imm_sel_o   = rv_pkg::imm_b;
                src_b_sel_o = 1'b0; // flags compare rs1 and rs2
                pc_src_o    = taken;
            end
            rv_pkg::op_jal: begin
                reg_wr_en_o  = 1'b1;
                imm_sel_o    = rv_pkg::imm_j;
                result_sel_o = rv_pkg::res_pc4;
                pc_src_o     = 1'b1;
            end
            rv_pkg::op_jalr: begin
                reg_wr_en_o  = 1'b1;
                result_sel_o = rv_pkg::res_pc4;
                pc_src_o     = 1'b1;
                jalr_sel_o   = 1'b1;
            end
            rv_pkg::op_lui: begin
                reg_wr_en_o = 1'b1;
                imm_sel_o   = rv_pkg::imm_u;
                src_a_sel_o = rv_pkg::src_a_zero; // 0 + imm
            end
            rv_pkg::op_auipc: begin
                reg_wr_en_o = 1'b1;
                imm_sel_o   = rv_pkg::imm_u;
                src_a_sel_o = rv_pkg::src_a_pc;   // pc + imm
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/data_mem.sv
`timescale 1ns/10ps
`default_nettype none

module data_mem (
    input  logic                    clk,
    input  logic [rv_pkg::xlen-1:0] addr_i,    // byte address
    input  logic [rv_pkg::xlen-1:0] wr_data_i,
    input  logic                    wr_en_i,
    output logic [rv_pkg::xlen-1:0] rd_data_o
);

    logic [rv_pkg::xlen-1:0]    ram [rv_pkg::dmem_words];
    logic [rv_pkg::dmem_aw-1:0] widx;

    // word index, byte offset dropped
    // upper address bits wrap
    assign widx = addr_i[rv_pkg::dmem_aw+1:2];

    // write lands on the retiring edge
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            ram[widx] <= wr_data_i;
        end
    end

    // lw result visible same cycle
    assign rd_data_o = ram[widx];

endmodule

`default_nettype wire

//--- verilog/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    trigger_i,
    input  logic                    pc_src_i,  // 1 = take target
    input  logic [rv_pkg::xlen-1:0] target_i,
    output logic [rv_pkg::xlen-1:0] pc_o,
    output logic [rv_pkg::xlen-1:0] instr_o,
    output logic                    run_o      // low = core stalled
);

    logic                    run_q;
    logic [rv_pkg::xlen-1:0] pc_q;
    logic [rv_pkg::xlen-1:0] pc_plus4;
    logic [rv_pkg::xlen-1:0] pc_next;
    logic [rv_pkg::xlen-1:0] rom [rv_pkg::imem_words];

    // program image, same file the testbench reads
    initial begin
        $readmemh("program.hex", rom);
    end

    // run latch, sticky until reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run_q <= 1'b0;
        end else if (trigger_i) begin
            run_q <= 1'b1;
        end
    end

    assign pc_plus4 = pc_q + 32'd4;
    assign pc_next  = pc_src_i ? target_i : pc_plus4; // jump/taken branch

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_q <= rv_pkg::reset_pc;
        end else if (run_q) begin // one retire per edge once running
            pc_q <= pc_next;
        end
    end

    assign instr_o = rom[pc_q[rv_pkg::imem_aw+1:2]]; // word index
    assign pc_o    = pc_q;
    assign run_o   = run_q;

endmodule

`default_nettype wire

//--- verilog/imm_gen.sv
`timescale 1ns/10ps
`default_nettype none

module imm_gen (
    input  rv_pkg::instr_u          instr_i,
    input  rv_pkg::imm_sel_e        imm_sel_i,
    output logic [rv_pkg::xlen-1:0] imm_o
);

    logic sign; // instr bit 31 in every format

    assign sign = instr_i.i.imm12[11];

    always_comb begin
        case (imm_sel_i)
            rv_pkg::imm_s: imm_o = {{20{sign}}, instr_i.i.imm12[11:5], instr_i.i.rd};
            rv_pkg::imm_b: imm_o = {{19{sign}}, sign, instr_i.i.rd[0],
                                    instr_i.i.imm12[10:5], instr_i.i.rd[4:1], 1'b0};
            rv_pkg::imm_u: imm_o = {instr_i.u.imm20, 12'h000};
            // j bits sit as [31|19:12|20|30:21] in imm20
            rv_pkg::imm_j: imm_o = {{11{sign}}, sign, instr_i.u.imm20[7:0],
                                    instr_i.u.imm20[8], instr_i.u.imm20[18:9], 1'b0};
            default:       imm_o = {{20{sign}}, instr_i.i.imm12}; // i type
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/register_file.sv
`timescale 1ns/10ps
`default_nettype none

module register_file (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [rv_pkg::reg_aw-1:0] rs1_i,
    input  logic [rv_pkg::reg_aw-1:0] rs2_i,
    input  logic [rv_pkg::reg_aw-1:0] rd_i,
    input  logic [rv_pkg::xlen-1:0]   wr_data_i,
    input  logic                      wr_en_i,
    output logic [rv_pkg::xlen-1:0]   rd1_o,
    output logic [rv_pkg::xlen-1:0]   rd2_o,
    output logic [rv_pkg::xlen-1:0]   a0_o
);

    logic [rv_pkg::xlen-1:0] regs [2**rv_pkg::reg_aw];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int k = 0; k < 2**rv_pkg::reg_aw; k++) begin
                regs[k] <= '0;
            end
        end else if (wr_en_i && (rd_i != '0)) begin // x0 never written
            regs[rd_i] <= wr_data_i;
        end
    end

    assign rd1_o = regs[rs1_i]; // async reads
    assign rd2_o = regs[rs2_i];
    assign a0_o  = regs[10];    // x10 tap for the port

endmodule

`default_nettype wire

//--- verilog/rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    trigger_i,
    output logic [rv_pkg::xlen-1:0] pc_o,
    output logic [rv_pkg::xlen-1:0] instr_o,
    output logic [rv_pkg::xlen-1:0] a0_o
);

    logic [rv_pkg::xlen-1:0] pc;
    rv_pkg::instr_u          instr;
    logic                    run;
    logic                    reg_wr_en;
    logic                    mem_wr_en;
    logic                    reg_we;      // gated by run
    logic                    mem_we;
    rv_pkg::imm_sel_e        imm_sel;
    rv_pkg::alu_op_e         alu_op;
    logic [1:0]              src_a_sel;
    logic                    src_b_sel;
    logic [1:0]              result_sel;
    logic                    pc_src;
    logic                    jalr_sel;
    logic [rv_pkg::xlen-1:0] imm;
    logic [rv_pkg::xlen-1:0] rd1;
    logic [rv_pkg::xlen-1:0] rd2;
    logic [rv_pkg::xlen-1:0] src_a;
    logic [rv_pkg::xlen-1:0] src_b;
    logic [rv_pkg::xlen-1:0] alu_result;
    logic                    eq;
    logic                    lt;
    logic                    ltu;
    logic [rv_pkg::xlen-1:0] mem_rdata;
    logic [rv_pkg::xlen-1:0] pc_plus4;    // link value
    logic [rv_pkg::xlen-1:0] target;
    logic [rv_pkg::xlen-1:0] result;

    fetch_unit u_fetch (
        .clk(clk), .rst(rst), .trigger_i(trigger_i),
        .pc_src_i(pc_src), .target_i(target),
        .pc_o(pc), .instr_o(instr), .run_o(run)
    );

    control_unit u_ctrl (
        .instr_i(instr), .eq_i(eq), .lt_i(lt), .ltu_i(ltu),
        .reg_wr_en_o(reg_wr_en), .mem_wr_en_o(mem_wr_en),
        .imm_sel_o(imm_sel), .alu_op_o(alu_op),
        .src_a_sel_o(src_a_sel), .src_b_sel_o(src_b_sel),
        .result_sel_o(result_sel), .pc_src_o(pc_src), .jalr_sel_o(jalr_sel)
    );

    imm_gen u_imm (.instr_i(instr), .imm_sel_i(imm_sel), .imm_o(imm));

    register_file u_rf (
        .clk(clk), .rst(rst),
        .rs1_i(instr.r.rs1), .rs2_i(instr.r.rs2), .rd_i(instr.r.rd),
        .wr_data_i(result), .wr_en_i(reg_we),
        .rd1_o(rd1), .rd2_o(rd2), .a0_o(a0_o)
    );

    alu u_alu (
        .a_i(src_a), .b_i(src_b), .op_i(alu_op),
        .result_o(alu_result), .eq_o(eq), .lt_o(lt), .ltu_o(ltu)
    );

    data_mem u_dmem (
        .clk(clk), .addr_i(alu_result), .wr_data_i(rd2),
        .wr_en_i(mem_we), .rd_data_o(mem_rdata)
    );

    // nothing architectural changes before the trigger
    assign reg_we = reg_wr_en & run;
    assign mem_we = mem_wr_en & run;

    always_comb begin
        case (src_a_sel)
            rv_pkg::src_a_pc:   src_a = pc;
            rv_pkg::src_a_zero: src_a = '0;
            default:            src_a = rd1;
        endcase
    end

    assign src_b    = src_b_sel ? imm : rd2;
    assign pc_plus4 = pc + 32'd4;

    // jalr clears bit 0 of rs1 + imm
    assign target = jalr_sel ? ((rd1 + imm) & ~32'd1) : (pc + imm);

    always_comb begin
        case (result_sel)
            rv_pkg::res_mem: result = mem_rdata;
            rv_pkg::res_pc4: result = pc_plus4;
            default:         result = alu_result;
        endcase
    end

    assign pc_o    = pc;
    assign instr_o = instr;

endmodule

`default_nettype wire

//--- verilog/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;                    // data and address width
    localparam int imem_words = 64;              // instruction rom depth
    localparam int dmem_words = 64;              // data ram depth
    localparam int imem_aw = $clog2(imem_words); // rom word index bits
    localparam int dmem_aw = $clog2(dmem_words); // ram word index bits
    localparam int reg_aw = 5;                   // x0..x31
    localparam logic [xlen-1:0] reset_pc = '0;

    // rv32i major opcodes
    localparam logic [6:0] op_rtype  = 7'b0110011;
    localparam logic [6:0] op_itype  = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;

    // alu source a select
    localparam logic [1:0] src_a_reg  = 2'd0;
    localparam logic [1:0] src_a_pc   = 2'd1; // auipc
    localparam logic [1:0] src_a_zero = 2'd2; // lui

    // register write-back select
    localparam logic [1:0] res_alu = 2'd0;
    localparam logic [1:0] res_mem = 2'd1;
    localparam logic [1:0] res_pc4 = 2'd2; // link address

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra
    } alu_op_e;

    typedef enum logic [2:0] {
        imm_i, imm_s, imm_b, imm_u, imm_j
    } imm_sel_e;

    // one instruction word, three field layouts
    typedef union packed {
        struct packed {
            logic [6:0]        funct7;
            logic [reg_aw-1:0] rs2;
            logic [reg_aw-1:0] rs1;
            logic [2:0]        funct3;
            logic [reg_aw-1:0] rd;
            logic [6:0]        opcode;
        } r;
        struct packed {
            logic [11:0]       imm12;  // also s/b upper bits
            logic [reg_aw-1:0] rs1;
            logic [2:0]        funct3;
            logic [reg_aw-1:0] rd;     // s/b low imm bits live here
            logic [6:0]        opcode;
        } i;
        struct packed {
            logic [19:0]       imm20;  // u imm, scrambled j imm
            logic [reg_aw-1:0] rd;
            logic [6:0]        opcode;
        } u;
    } instr_u;

endpackage

`default_nettype wire
